/* rtl/cpuPkg.sv */
package cpuPkg;

   // data, address and register widths
   typedef logic [15:0] wordT;
   typedef logic [15:0] addrT;
   typedef logic [2:0]  regIdxT;
   typedef logic [3:0]  opcodeT;
   typedef logic [11:0] apbAddrT;

   localparam opcodeT OP_NOP  = 4'd0;
   localparam opcodeT OP_ADD  = 4'd1;
   localparam opcodeT OP_SUB  = 4'd2;
   localparam opcodeT OP_ADDI = 4'd3;
   localparam opcodeT OP_LI   = 4'd4;
   localparam opcodeT OP_BEQZ = 4'd5;
   localparam opcodeT OP_HALT = 4'd15;

   // instruction field positions
   localparam int OP_LSB = 12;
   localparam int RD_LSB = 9;
   localparam int RS_LSB = 6;
   localparam int RT_LSB = 3;

   // apb word address is split into region and offset
   localparam int REGION_LSB = 10;
   localparam logic [1:0] REGION_MEM  = 2'd0;
   localparam logic [1:0] REGION_REG  = 2'd1;
   localparam logic [1:0] REGION_CTRL = 2'd2;
   localparam logic [9:0] CTRL_RUN = 10'd0;
   localparam logic [9:0] STATUS   = 10'd1;
   localparam logic [9:0] RETIRED  = 10'd2;

   typedef enum logic [1:0] {
      IDLE,
      RUN,
      HALTED
   } runStateT;

   typedef struct packed {
      logic valid;
      addrT pc;
      wordT instr;
   } fetchDecT;

   typedef struct packed {
      logic   valid;
      opcodeT op;
      regIdxT rd;
      logic   regWrite;
      logic   isBranch;
      logic   isHalt;
      wordT   opA;
      wordT   opB;
      addrT   pcNext;
      wordT   imm;
   } decExT;

   typedef struct packed {
      logic   valid;
      regIdxT rd;
      logic   regWrite;
      wordT   result;
      logic   isBranch;
      logic   branchTaken;
      addrT   target;
      logic   isHalt;
   } exWbT;

endpackage

/* rtl/progMem.sv */
module progMem #(
   parameter int MEM_WORDS = 256
) (
   input  logic                         clk,
   input  cpuPkg::addrT                 rdAddr,
   output cpuPkg::wordT                 rdData,
   input  logic                         wrEn,
   input  logic [$clog2(MEM_WORDS)-1:0] wrIdx,
   input  cpuPkg::wordT                 wrData,
   output cpuPkg::wordT                 apbData
);
   localparam int IDX_W = $clog2(MEM_WORDS);

   cpuPkg::wordT mem [MEM_WORDS];

   // byte address to word index, upper bits dropped so reads wrap
   assign rdData = mem[rdAddr[IDX_W:1]];

   // apb readback uses the same index as the write port
   assign apbData = mem[wrIdx];

   always_ff @(posedge clk) begin
      if (wrEn) begin
         mem[wrIdx] <= wrData;
      end
   end

endmodule

/* rtl/fetchStage.sv */
module fetchStage (
   input  logic             clk,
   input  logic             arstN,
   input  logic             run,
   input  logic             flush,
   input  logic             stall,
   input  logic             redirect,
   input  cpuPkg::addrT     target,
   output cpuPkg::addrT     memAddr,
   input  cpuPkg::wordT     memData,
   output cpuPkg::fetchDecT fetchOut
);
   cpuPkg::addrT pc;
   cpuPkg::addrT pcInc;

   assign pcInc = pc + 16'd2;
   assign memAddr = pc;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pc <= '0;
         fetchOut <= '0;
      end else if (flush) begin
         pc <= '0;
         fetchOut <= '0;
      end else if (redirect) begin
         // taken branch in writeback, the slot after it is a bubble
         pc <= target;
         fetchOut <= '0;
      end else if (run && !stall) begin
         pc <= pcInc;
         fetchOut.valid <= 1'b1;
         fetchOut.pc <= pcInc;
         fetchOut.instr <= memData;
      end else begin
         // pc holds, decode gets a bubble
         fetchOut <= '0;
      end
   end

endmodule

/* rtl/hazardUnit.sv */
module hazardUnit (
   input  cpuPkg::wordT  fetchInstr,
   input  cpuPkg::decExT decInfo,
   input  cpuPkg::exWbT  exInfo,
   output logic          stall
);
   cpuPkg::opcodeT op;
   cpuPkg::regIdxT rs;
   cpuPkg::regIdxT rt;
   logic readsRs;
   logic readsRt;
   logic decWrites;
   logic exWrites;
   logic rsHit;
   logic rtHit;
   logic branchBusy;

   assign op = fetchInstr[cpuPkg::OP_LSB +: 4];
   assign rs = fetchInstr[cpuPkg::RS_LSB +: 3];
   assign rt = fetchInstr[cpuPkg::RT_LSB +: 3];

   // source registers by opcode
   always_comb begin
      readsRs = 1'b0;
      readsRt = 1'b0;
      case (op)
         cpuPkg::OP_ADD, cpuPkg::OP_SUB: begin
            readsRs = 1'b1;
            readsRt = 1'b1;
         end
         cpuPkg::OP_ADDI, cpuPkg::OP_BEQZ: readsRs = 1'b1;
         default: ;
      endcase
   end

   assign decWrites = decInfo.valid && decInfo.regWrite;
   assign exWrites = exInfo.valid && exInfo.regWrite;

   // r0 never conflicts, writeback is covered by the register file bypass
   assign rsHit = readsRs && (rs != '0) &&
                  ((decWrites && decInfo.rd == rs) || (exWrites && exInfo.rd == rs));
   assign rtHit = readsRt && (rt != '0) &&
                  ((decWrites && decInfo.rd == rt) || (exWrites && exInfo.rd == rt));

   assign branchBusy = (decInfo.valid && decInfo.isBranch) || (exInfo.valid && exInfo.isBranch);

   assign stall = rsHit || rtHit || branchBusy;

endmodule

/* rtl/decodeStage.sv */
module decodeStage (
   input  logic             clk,
   input  logic             arstN,
   input  logic             flush,
   input  cpuPkg::fetchDecT fetchIn,
   input  logic             wbEn,
   input  cpuPkg::regIdxT   wbIdx,
   input  cpuPkg::wordT     wbData,
   input  cpuPkg::regIdxT   dbgIdx,
   output cpuPkg::wordT     dbgData,
   output cpuPkg::decExT    decInfo,
   output cpuPkg::decExT    decOut
);
   cpuPkg::wordT regs [8];
   cpuPkg::opcodeT op;
   cpuPkg::regIdxT rs;
   cpuPkg::regIdxT rt;
   cpuPkg::wordT imm6;
   cpuPkg::wordT imm8;

   // read with write-through from the writeback port
   function automatic cpuPkg::wordT readReg(input cpuPkg::regIdxT idx);
      if (idx == '0) begin
         return '0;
      end else if (wbEn && wbIdx == idx) begin
         return wbData;
      end
      return regs[idx];
   endfunction

   assign op = fetchIn.instr[cpuPkg::OP_LSB +: 4];
   assign rs = fetchIn.instr[cpuPkg::RS_LSB +: 3];
   assign rt = fetchIn.instr[cpuPkg::RT_LSB +: 3];
   assign imm6 = {{10{fetchIn.instr[5]}}, fetchIn.instr[5:0]};
   assign imm8 = {8'b0, fetchIn.instr[7:0]};

   always_comb begin
      dbgData = readReg(dbgIdx);
      decInfo = '0;
      decInfo.valid = fetchIn.valid;
      decInfo.op = op;
      decInfo.rd = fetchIn.instr[cpuPkg::RD_LSB +: 3];
      decInfo.opA = readReg(rs);
      decInfo.opB = readReg(rt);
      decInfo.pcNext = fetchIn.pc;
      decInfo.imm = (op == cpuPkg::OP_LI) ? imm8 : imm6;
      case (op)
         cpuPkg::OP_ADD, cpuPkg::OP_SUB, cpuPkg::OP_ADDI, cpuPkg::OP_LI: begin
            decInfo.regWrite = 1'b1;
         end
         cpuPkg::OP_BEQZ: decInfo.isBranch = 1'b1;
         cpuPkg::OP_HALT: decInfo.isHalt = 1'b1;
         // nop and unused opcodes only retire
         cpuPkg::OP_NOP: ;
         default: ;
      endcase
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         foreach (regs[i]) begin
            regs[i] <= '0;
         end
      end else if (wbEn && wbIdx != '0) begin
         regs[wbIdx] <= wbData;
      end
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         decOut <= '0;
      end else if (flush) begin
         decOut <= '0;
      end else begin
         decOut <= decInfo;
      end
   end

endmodule

/* rtl/executeStage.sv */
module executeStage (
   input  logic          clk,
   input  logic          arstN,
   input  logic          flush,
   input  cpuPkg::decExT decIn,
   output cpuPkg::exWbT  exInfo,
   output cpuPkg::exWbT  exOut
);

   always_comb begin
      exInfo = '0;
      exInfo.valid = decIn.valid;
      exInfo.rd = decIn.rd;
      exInfo.regWrite = decIn.regWrite;
      exInfo.isBranch = decIn.isBranch;
      exInfo.isHalt = decIn.isHalt;
      // beqz tests rs, offset counts in instruction words
      exInfo.branchTaken = decIn.isBranch && (decIn.opA == '0);
      exInfo.target = decIn.pcNext + {decIn.imm[14:0], 1'b0};
      case (decIn.op)
         cpuPkg::OP_ADD:  exInfo.result = decIn.opA + decIn.opB;
         cpuPkg::OP_SUB:  exInfo.result = decIn.opA - decIn.opB;
         cpuPkg::OP_ADDI: exInfo.result = decIn.opA + decIn.imm;
         cpuPkg::OP_LI:   exInfo.result = decIn.imm;
         default:         exInfo.result = '0;
      endcase
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         exOut <= '0;
      end else if (flush) begin
         exOut <= '0;
      end else begin
         exOut <= exInfo;
      end
   end

endmodule

/* rtl/writebackStage.sv */
module writebackStage (
   input  logic           clk,
   input  logic           arstN,
   input  logic           flush,
   input  cpuPkg::exWbT   exIn,
   output logic           wbEn,
   output cpuPkg::regIdxT wbIdx,
   output cpuPkg::wordT   wbData,
   output logic           redirect,
   output cpuPkg::addrT   target,
   output logic           haltSeen,
   output cpuPkg::wordT   retiredCount
);
   logic retire;

   assign haltSeen = exIn.valid && exIn.isHalt;

   // flush squashes the entry, except the halt that raised it
   assign retire = exIn.valid && (!flush || haltSeen);

   assign wbEn = exIn.valid && exIn.regWrite && !flush;
   assign wbIdx = exIn.rd;
   assign wbData = exIn.result;
   assign redirect = exIn.valid && exIn.branchTaken && !flush;
   assign target = exIn.target;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         retiredCount <= '0;
      end else if (retire) begin
         retiredCount <= retiredCount + 16'd1;
      end else if (flush) begin
         retiredCount <= '0;
      end
   end

endmodule

/* rtl/apbCtrl.sv */
module apbCtrl #(
   parameter int MEM_WORDS = 256
) (
   input  logic                         clk,
   input  logic                         arstN,
   input  logic                         psel,
   input  logic                         penable,
   input  logic                         pwrite,
   input  cpuPkg::apbAddrT              paddr,
   input  cpuPkg::wordT                 pwdata,
   output cpuPkg::wordT                 prdata,
   output logic                         pready,
   output logic                         memWrEn,
   output logic [$clog2(MEM_WORDS)-1:0] memWrIdx,
   output cpuPkg::wordT                 memWrData,
   input  cpuPkg::wordT                 memRdData,
   output cpuPkg::regIdxT               dbgIdx,
   input  cpuPkg::wordT                 dbgData,
   input  logic                         haltSeen,
   input  cpuPkg::wordT                 retiredCount,
   output logic                         run,
   output logic                         flush,
   output logic                         halted,
   output logic                         running
);
   localparam int IDX_W = $clog2(MEM_WORDS);

   cpuPkg::runStateT state;
   cpuPkg::runStateT stateNext;
   logic [1:0] region;
   logic [9:0] offset;
   logic wrAccess;
   logic ctrlWr;

   assign region = paddr[cpuPkg::REGION_LSB +: 2];
   assign offset = paddr[cpuPkg::REGION_LSB-1:0];
   assign pready = 1'b1;

   // writes land at the end of the access cycle
   assign wrAccess = psel && penable && pwrite;
   assign ctrlWr = wrAccess && region == cpuPkg::REGION_CTRL && offset == cpuPkg::CTRL_RUN;

   assign memWrEn = wrAccess && region == cpuPkg::REGION_MEM;
   assign memWrIdx = paddr[IDX_W-1:0];
   assign memWrData = pwdata;
   assign dbgIdx = paddr[2:0];

   always_comb begin
      case (region)
         cpuPkg::REGION_MEM: prdata = memRdData;
         cpuPkg::REGION_REG: prdata = dbgData;
         cpuPkg::REGION_CTRL: begin
            case (offset)
               cpuPkg::CTRL_RUN: prdata = {15'b0, running};
               cpuPkg::STATUS:   prdata = {14'b0, halted, running};
               cpuPkg::RETIRED:  prdata = retiredCount;
               default:          prdata = '0;
            endcase
         end
         default: prdata = '0;
      endcase
   end

   // run control, a stop request wins over a halt in the same cycle
   always_comb begin
      stateNext = state;
      case (state)
         cpuPkg::IDLE: begin
            if (ctrlWr && pwdata[0]) begin
               stateNext = cpuPkg::RUN;
            end
         end
         cpuPkg::RUN: begin
            if (ctrlWr && !pwdata[0]) begin
               stateNext = cpuPkg::IDLE;
            end else if (haltSeen) begin
               stateNext = cpuPkg::HALTED;
            end
         end
         cpuPkg::HALTED: begin
            if (ctrlWr && !pwdata[0]) begin
               stateNext = cpuPkg::IDLE;
            end
         end
         default: stateNext = cpuPkg::IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state <= cpuPkg::IDLE;
      end else begin
         state <= stateNext;
      end
   end

   assign run = state == cpuPkg::RUN;
   assign running = run;
   assign halted = state == cpuPkg::HALTED;
   // a retiring halt also squashes the younger instructions behind it
   assign flush = state == cpuPkg::IDLE || haltSeen;

endmodule

/* rtl/cpuTop.sv */
module cpuTop #(
   parameter int MEM_WORDS = 256
) (
   input  logic            clk,
   input  logic            arstN,
   input  logic            psel,
   input  logic            penable,
   input  logic            pwrite,
   input  cpuPkg::apbAddrT paddr,
   input  cpuPkg::wordT    pwdata,
   output cpuPkg::wordT    prdata,
   output logic            pready,
   output logic            halted,
   output logic            running
);
   cpuPkg::fetchDecT fetchOut;
   cpuPkg::decExT decInfo;
   cpuPkg::decExT decOut;
   cpuPkg::exWbT exInfo;
   cpuPkg::exWbT exOut;
   cpuPkg::addrT memAddr;
   cpuPkg::wordT memData;
   cpuPkg::wordT apbMemData;
   logic memWrEn;
   logic [$clog2(MEM_WORDS)-1:0] memWrIdx;
   cpuPkg::wordT memWrData;
   cpuPkg::regIdxT dbgIdx;
   cpuPkg::wordT dbgData;
   logic stall;
   logic run;
   logic flush;
   logic wbEn;
   cpuPkg::regIdxT wbIdx;
   cpuPkg::wordT wbData;
   logic redirect;
   cpuPkg::addrT target;
   logic haltSeen;
   cpuPkg::wordT retiredCount;

   progMem #(.MEM_WORDS(MEM_WORDS)) progMem_inst (
      .clk(clk), .rdAddr(memAddr), .rdData(memData), .wrEn(memWrEn),
      .wrIdx(memWrIdx), .wrData(memWrData), .apbData(apbMemData)
   );

   fetchStage fetchStage_inst (
      .clk(clk), .arstN(arstN), .run(run), .flush(flush), .stall(stall),
      .redirect(redirect), .target(target), .memAddr(memAddr), .memData(memData),
      .fetchOut(fetchOut)
   );

   hazardUnit hazardUnit_inst (
      .fetchInstr(memData), .decInfo(decInfo), .exInfo(exInfo), .stall(stall)
   );

   decodeStage decodeStage_inst (
      .clk(clk), .arstN(arstN), .flush(flush), .fetchIn(fetchOut), .wbEn(wbEn),
      .wbIdx(wbIdx), .wbData(wbData), .dbgIdx(dbgIdx), .dbgData(dbgData),
      .decInfo(decInfo), .decOut(decOut)
   );

   executeStage executeStage_inst (
      .clk(clk), .arstN(arstN), .flush(flush), .decIn(decOut), .exInfo(exInfo),
      .exOut(exOut)
   );

   writebackStage writebackStage_inst (
      .clk(clk), .arstN(arstN), .flush(flush), .exIn(exOut), .wbEn(wbEn),
      .wbIdx(wbIdx), .wbData(wbData), .redirect(redirect), .target(target),
      .haltSeen(haltSeen), .retiredCount(retiredCount)
   );

   apbCtrl #(.MEM_WORDS(MEM_WORDS)) apbCtrl_inst (
      .clk(clk), .arstN(arstN), .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
      .memWrEn(memWrEn), .memWrIdx(memWrIdx), .memWrData(memWrData),
      .memRdData(apbMemData), .dbgIdx(dbgIdx), .dbgData(dbgData),
      .haltSeen(haltSeen), .retiredCount(retiredCount), .run(run), .flush(flush),
      .halted(halted), .running(running)
   );

endmodule

/* verif/clkGen.sv */
module clkGen (
   output logic clk,
   output logic arstN
);
   timeunit 1ns;
   timeprecision 1ps;

   // 40 ns period
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // reset held low for the first 8 rising edges
   initial begin
      arstN = 1'b0;
      repeat (8) @(posedge clk);
      arstN <= 1'b1;
   end

endmodule

/* verif/cpuTop_assert.sv */
module cpuTopAssert (
   input logic         clk,
   input logic         arstN,
   input logic         stall,
   input logic         flush,
   input logic         redirect,
   input cpuPkg::addrT target,
   input cpuPkg::addrT pc,
   input logic         fetchValid,
   input logic         wbEn,
   input logic         haltSeen,
   input logic         halted,
   input logic         running,
   input logic         pready
);
   timeunit 1ns;
   timeprecision 1ps;

   int failCount = 0;

   // a stalled fetch keeps the pc and hands decode a bubble
   stallHoldsPc: assert property (@(posedge clk) disable iff (!arstN)
      stall && !flush && !redirect |=> pc == $past(pc) && !fetchValid)
      else begin
         failCount++;
         $error("pc moved or a valid entry reached decode during a stall");
      end

   // taken branch in writeback
   redirectLoadsTarget: assert property (@(posedge clk) disable iff (!arstN)
      redirect |=> pc == $past(target))
      else begin
         failCount++;
         $error("pc after a redirect differs from the branch target");
      end

   noWriteWhenHalted: assert property (@(posedge clk) disable iff (!arstN)
      halted |-> !wbEn)
      else begin
         failCount++;
         $error("register write while the core is halted");
      end

   haltFollowsRetire: assert property (@(posedge clk) disable iff (!arstN)
      $rose(halted) |-> $past(haltSeen))
      else begin
         failCount++;
         $error("halted rose without a halt instruction in writeback");
      end

   apbStatusRules: assert property (@(posedge clk) disable iff (!arstN)
      pready && !(running && halted))
      else begin
         failCount++;
         $error("pready low, or running and halted high together");
      end

endmodule

/* verif/cpuTb.sv */
module cpuTb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int MEM_WORDS = 256;
   // about 120 apb transfers of 3 cycles plus roughly 250 cycles of
   // program execution, so this leaves a wide margin
   localparam int CYCLE_LIMIT = 2000;
   localparam logic [31:0] SEED = 32'h8596_c8d7;

   logic clk;
   logic arstN;
   logic psel;
   logic penable;
   logic pwrite;
   cpuPkg::apbAddrT paddr;
   cpuPkg::wordT pwdata;
   cpuPkg::wordT prdata;
   logic pready;
   logic halted;
   logic running;

   cpuPkg::wordT prog[$];
   cpuPkg::wordT modelRegs [8] = '{default: 16'h0000};
   int modelRetired = 0;
   int checkErrors = 0;
   int cycleCount = 0;

   clkGen clkGen_inst (.clk(clk), .arstN(arstN));

   cpuTop #(.MEM_WORDS(MEM_WORDS)) cpuTop_inst (
      .clk(clk), .arstN(arstN), .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
      .halted(halted), .running(running)
   );

   bind cpuTop cpuTopAssert cpuTopAssert_inst (
      .clk(clk), .arstN(arstN), .stall(stall), .flush(flush), .redirect(redirect),
      .target(target), .pc(memAddr), .fetchValid(fetchOut.valid), .wbEn(wbEn),
      .haltSeen(haltSeen), .halted(halted), .running(running), .pready(pready)
   );

   function automatic cpuPkg::wordT encReg(input cpuPkg::opcodeT op,
         input cpuPkg::regIdxT rd, input cpuPkg::regIdxT rs, input cpuPkg::regIdxT rt);
      return {op, rd, rs, rt, 3'b000};
   endfunction

   function automatic cpuPkg::wordT encImm(input cpuPkg::opcodeT op,
         input cpuPkg::regIdxT rd, input cpuPkg::regIdxT rs, input int imm);
      return {op, rd, rs, imm[5:0]};
   endfunction

   function automatic cpuPkg::wordT encLi(input cpuPkg::regIdxT rd, input logic [7:0] imm);
      return {cpuPkg::OP_LI, rd, 1'b0, imm};
   endfunction

   function automatic cpuPkg::apbAddrT memWordAddr(input int idx);
      return {cpuPkg::REGION_MEM, idx[9:0]};
   endfunction

   function automatic cpuPkg::apbAddrT regWordAddr(input cpuPkg::regIdxT r);
      return {cpuPkg::REGION_REG, 7'b0, r};
   endfunction

   function automatic cpuPkg::apbAddrT ctrlWordAddr(input logic [9:0] offset);
      return {cpuPkg::REGION_CTRL, offset};
   endfunction

   function automatic cpuPkg::wordT modelRead(input cpuPkg::regIdxT idx);
      return (idx == 3'd0) ? 16'h0000 : modelRegs[idx];
   endfunction

   function automatic void modelWrite(input cpuPkg::regIdxT idx, input cpuPkg::wordT val);
      if (idx != 3'd0) begin
         modelRegs[idx] = val;
      end
   endfunction

   // in-order ISA model, one instruction per step, stops at halt
   task automatic runModel();
      int pcIdx;
      int steps;
      logic done;
      cpuPkg::wordT instr;
      cpuPkg::regIdxT rd;
      cpuPkg::regIdxT rs;
      cpuPkg::regIdxT rt;
      cpuPkg::wordT simm;
      pcIdx = 0;
      steps = 0;
      done = 1'b0;
      modelRetired = 0;
      while (!done && steps < 500 && pcIdx < prog.size()) begin
         instr = prog[pcIdx];
         rd = instr[11:9];
         rs = instr[8:6];
         rt = instr[5:3];
         simm = {{10{instr[5]}}, instr[5:0]};
         modelRetired++;
         steps++;
         pcIdx++;
         case (instr[15:12])
            cpuPkg::OP_ADD:  modelWrite(rd, modelRead(rs) + modelRead(rt));
            cpuPkg::OP_SUB:  modelWrite(rd, modelRead(rs) - modelRead(rt));
            cpuPkg::OP_ADDI: modelWrite(rd, modelRead(rs) + simm);
            cpuPkg::OP_LI:   modelWrite(rd, {8'h00, instr[7:0]});
            cpuPkg::OP_BEQZ: begin
               // offset in words from the next instruction
               if (modelRead(rs) == 16'h0000) begin
                  pcIdx = pcIdx + int'($signed(instr[5:0]));
               end
            end
            cpuPkg::OP_HALT: done = 1'b1;
            default: ;
         endcase
      end
   endtask

   task automatic apbWrite(input cpuPkg::apbAddrT addr, input cpuPkg::wordT data);
      @(posedge clk);
      psel <= 1'b1;
      penable <= 1'b0;
      pwrite <= 1'b1;
      paddr <= addr;
      pwdata <= data;
      @(posedge clk);
      penable <= 1'b1;
      @(posedge clk);
      psel <= 1'b0;
      penable <= 1'b0;
      pwrite <= 1'b0;
   endtask

   task automatic apbRead(input cpuPkg::apbAddrT addr, output cpuPkg::wordT data);
      @(posedge clk);
      psel <= 1'b1;
      penable <= 1'b0;
      pwrite <= 1'b0;
      paddr <= addr;
      @(posedge clk);
      penable <= 1'b1;
      // prdata is settled by mid access cycle
      @(negedge clk);
      data = prdata;
      @(posedge clk);
      psel <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic checkValue(input string testName, input string what,
         input cpuPkg::wordT expected, input cpuPkg::wordT actual);
      assert (actual === expected) else begin
         checkErrors++;
         $display("** Error %s: %s expected %h, actual %h", testName, what, expected, actual);
      end
   endtask

   task automatic checkRegs(input string testName);
      int i;
      cpuPkg::wordT val;
      for (i = 0; i < 8; i++) begin
         apbRead(regWordAddr(3'(i)), val);
         checkValue(testName, $sformatf("r%0d", i), modelRead(3'(i)), val);
      end
   endtask

   task automatic checkStatus(input string testName, input cpuPkg::wordT status,
         input cpuPkg::wordT retired);
      cpuPkg::wordT val;
      apbRead(ctrlWordAddr(cpuPkg::STATUS), val);
      checkValue(testName, "status", status, val);
      apbRead(ctrlWordAddr(cpuPkg::RETIRED), val);
      checkValue(testName, "retired", retired, val);
   endtask

   task automatic loadProgram();
      int i;
      apbWrite(ctrlWordAddr(cpuPkg::CTRL_RUN), 16'h0000);
      for (i = 0; i < prog.size(); i++) begin
         apbWrite(memWordAddr(i), prog[i]);
      end
   endtask

   task automatic runProgram(input string testName);
      runModel();
      apbWrite(ctrlWordAddr(cpuPkg::CTRL_RUN), 16'h0001);
      // the core runs right after the start write, well before any halt
      @(negedge clk);
      checkValue(testName, "running pin", 16'h0001, {15'b0, running});
      checkValue(testName, "halted pin", 16'h0000, {15'b0, halted});
      while (!halted) begin
         @(negedge clk);
      end
      checkRegs(testName);
      // halted set, running clear
      checkStatus(testName, 16'h0002, 16'(modelRetired));
   endtask

   task automatic memoryLoadTest();
      cpuPkg::wordT shadow [int];
      cpuPkg::wordT data;
      int idx;
      int i;
      for (i = 0; i < 16; i++) begin
         idx = int'($urandom_range(MEM_WORDS - 1, 0));
         data = 16'($urandom());
         shadow[idx] = data;
         apbWrite(memWordAddr(idx), data);
      end
      foreach (shadow[a]) begin
         apbRead(memWordAddr(a), data);
         checkValue("program load", $sformatf("mem[%0d]", a), shadow[a], data);
      end
   endtask

   task automatic arithmeticTest();
      logic [7:0] seedVal;
      // kept below 128 so the branch test's skipped values stay distinct
      seedVal = 8'($urandom_range(127, 1));
      prog.delete();
      prog.push_back(encLi(3'd1, seedVal));
      prog.push_back(encImm(cpuPkg::OP_ADDI, 3'd2, 3'd1, 3));
      prog.push_back(encReg(cpuPkg::OP_ADD, 3'd3, 3'd2, 3'd1));
      prog.push_back(encReg(cpuPkg::OP_SUB, 3'd4, 3'd3, 3'd2));
      prog.push_back(encImm(cpuPkg::OP_ADDI, 3'd5, 3'd4, -7));
      prog.push_back(encLi(3'd6, 8'hF0));
      prog.push_back(encReg(cpuPkg::OP_SUB, 3'd7, 3'd6, 3'd5));
      prog.push_back(encReg(cpuPkg::OP_ADD, 3'd0, 3'd7, 3'd7));
      prog.push_back(encImm(cpuPkg::OP_ADDI, 3'd1, 3'd0, 1));
      prog.push_back(16'h0000);
      prog.push_back({cpuPkg::OP_HALT, 12'h000});
      loadProgram();
      runProgram("arith raw");
   endtask

   task automatic branchTest();
      prog.delete();
      prog.push_back(encLi(3'd1, 8'h00));
      prog.push_back(encImm(cpuPkg::OP_BEQZ, 3'd0, 3'd1, 2));
      // skipped by the taken branch above
      prog.push_back(encLi(3'd2, 8'hEE));
      prog.push_back(encLi(3'd3, 8'hDC));
      prog.push_back(encLi(3'd4, 8'h03));
      prog.push_back(encImm(cpuPkg::OP_BEQZ, 3'd0, 3'd4, 1));
      prog.push_back(encLi(3'd5, 8'h33));
      prog.push_back(encLi(3'd6, 8'h00));
      // countdown loop on r4, r6 gathers 2 per pass
      prog.push_back(encImm(cpuPkg::OP_ADDI, 3'd6, 3'd6, 2));
      prog.push_back(encImm(cpuPkg::OP_ADDI, 3'd4, 3'd4, -1));
      prog.push_back(encImm(cpuPkg::OP_BEQZ, 3'd0, 3'd4, 1));
      prog.push_back(encImm(cpuPkg::OP_BEQZ, 3'd0, 3'd0, -4));
      prog.push_back({cpuPkg::OP_HALT, 12'h000});
      loadProgram();
      runProgram("branch");
   endtask

   task automatic restartTest();
      apbWrite(ctrlWordAddr(cpuPkg::CTRL_RUN), 16'h0000);
      checkStatus("restart idle", 16'h0000, 16'h0000);
      runProgram("restart");
   endtask

   task automatic haltSquashTest();
      prog.delete();
      prog.push_back(encLi(3'd1, 8'h0A));
      prog.push_back(encLi(3'd2, 8'h0B));
      prog.push_back({cpuPkg::OP_HALT, 12'h000});
      // younger than the halt, never retire
      prog.push_back(encLi(3'd1, 8'h99));
      prog.push_back(encImm(cpuPkg::OP_ADDI, 3'd2, 3'd2, 1));
      prog.push_back(encLi(3'd3, 8'h77));
      loadProgram();
      runProgram("halt squash");
   endtask

   // watchdog
   initial begin
      while (cycleCount < CYCLE_LIMIT) begin
         @(posedge clk);
         cycleCount++;
      end
      $display("timeout: the run did not finish within %0d cycles (halted=%0b)",
               CYCLE_LIMIT, halted);
      $display("errors: check %0d, assertion %0d", checkErrors,
               cpuTop_inst.cpuTopAssert_inst.failCount);
      $display("=== FAIL ===");
      $finish;
   end

   initial begin
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      void'($urandom(SEED));
      wait (arstN === 1'b1);
      checkStatus("reset", 16'h0000, 16'h0000);
      memoryLoadTest();
      arithmeticTest();
      branchTest();
      restartTest();
      haltSquashTest();
      repeat (2) @(posedge clk);
      $display("errors: check %0d, assertion %0d", checkErrors,
               cpuTop_inst.cpuTopAssert_inst.failCount);
      if (checkErrors == 0 && cpuTop_inst.cpuTopAssert_inst.failCount == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

/* files.f */
rtl/cpuPkg.sv
rtl/progMem.sv
rtl/fetchStage.sv
rtl/hazardUnit.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/writebackStage.sv
rtl/apbCtrl.sv
rtl/cpuTop.sv
verif/clkGen.sv
verif/cpuTop_assert.sv
verif/cpuTb.sv

/* Makefile */
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps --top-module cpuTb -f files.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module cpuTb -f files.f -o simv
	./obj_dir/simv +verilator+error+limit+100 2>&1 | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
